// File: dv/sd_card_model.sv
// behavioral sd card in spi mode 3
// records mosi bytes and answers with the previous byte xor 0xa5
`timescale 1ns/1ps

module sd_card_model (
  input  logic       sclk_i,
  input  logic       mosi_i,
  input  logic       ss_i,
  output logic       miso_o,
  output logic [7:0] last_rx_o,
  output int         byte_count_o,
  output int         idle_edges_o
);

  // first answer after power up is all ones
  logic [7:0] answer = 8'hff;
  logic [7:0] tx_sr = 8'hff;
  logic [7:0] rx_sr = 8'h00;
  logic [7:0] last_rx = 8'h00;
  logic       miso_q = 1'b1;
  logic       mosi_hold = 1'b1;
  int         bit_idx = 0;
  int         byte_count = 0;
  int         idle_edges = 0;

  // deselected card lets miso float high
  assign miso_o = ss_i ? 1'b1 : miso_q;

  // falling sclk, next answer bit out msb first
  always @(negedge sclk_i) begin
    if (!ss_i) begin
      if (bit_idx == 0) begin
        tx_sr = answer;
      end
      miso_q = tx_sr[7];
      tx_sr = {tx_sr[6:0], 1'b1};
      // mosi settles just after the falling edge
      #1;
      mosi_hold = mosi_i;
    end
  end

  // rising sclk, capture the held mosi bit
  always @(posedge sclk_i) begin
    if (!ss_i) begin
      rx_sr = {rx_sr[6:0], mosi_hold};
      bit_idx = bit_idx + 1;
      if (bit_idx == 8) begin
        bit_idx = 0;
        last_rx = rx_sr;
        answer = rx_sr ^ 8'ha5;
        byte_count = byte_count + 1;
      end
    end
  end

  // any sclk activity with the card deselected
  always @(posedge sclk_i or negedge sclk_i) begin
    if (ss_i === 1'b1) begin
      idle_edges = idle_edges + 1;
    end
  end

  assign last_rx_o    = last_rx;
  assign byte_count_o = byte_count;
  assign idle_edges_o = idle_edges;

endmodule

// File: dv/sdspi_tb.sv
// sd spi controller testbench
// random wishbone traffic against a card model, checked by a reference model
`timescale 1ns/1ps

module sdspi_tb import sdspi_pkg::*; ();

  localparam int       SEED      = 34263;
  localparam int       NUM_TXN   = 200;
  localparam clk_div_t DIV_TB    = 8'd3;
  localparam int       ACK_LIMIT = 16 * 256 + 8;
  // longest data access per transaction plus reset and slack
  localparam int       WATCHDOG_NS = NUM_TXN * 16 * 8 * 10 + 50000;

  logic       wb_clk_i = 1'b0;
  logic       reset_i;
  logic       wb_adr_i;
  wb_data_t   wb_dat_i;
  wb_data_t   wb_dat_o;
  logic       wb_we_i;
  logic [1:0] wb_sel_i;
  logic       wb_stb_i;
  logic       wb_cyc_i;
  logic       wb_ack_o;
  logic       sclk;
  logic       mosi;
  logic       miso;
  logic       ss;
  spi_byte_t  card_rx;
  int         card_bytes;
  int         card_idle_edges;

  // reference copy of the control register and card state
  logic       model_ss;
  clk_div_t   model_div;
  spi_byte_t  model_answer;
  int         model_bytes;
  int         idle_base;

  // 100 MHz bus clock
  always #5 wb_clk_i = ~wb_clk_i;

  sdspi_top #(
    .DIV_INIT (DIV_TB)
  ) uut (
    .wb_clk_i (wb_clk_i),
    .reset_i  (reset_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_we_i  (wb_we_i),
    .wb_sel_i (wb_sel_i),
    .wb_stb_i (wb_stb_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_ack_o (wb_ack_o),
    .sclk_o   (sclk),
    .mosi_o   (mosi),
    .miso_i   (miso),
    .ss_o     (ss)
  );

  sd_card_model card (
    .sclk_i       (sclk),
    .mosi_i       (mosi),
    .ss_i         (ss),
    .miso_o       (miso),
    .last_rx_o    (card_rx),
    .byte_count_o (card_bytes),
    .idle_edges_o (card_idle_edges)
  );

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge wb_clk_i);
    #1;
  endtask

  // one classic cycle, cycles counts edges from stb to the ack
  task automatic bus_access(input logic adr, input logic we, input logic [1:0] sel,
                            input wb_data_t dat, output wb_data_t rdata,
                            output int cycles);
    wb_adr_i = adr;
    wb_we_i  = we;
    wb_sel_i = sel;
    wb_dat_i = dat;
    wb_stb_i = 1'b1;
    wb_cyc_i = 1'b1;
    cycles   = 0;
    do begin
      next_cycle();
      cycles++;
      if (cycles > ACK_LIMIT) begin
        $display("no ack from the DUT within %0d cycles", ACK_LIMIT);
        abort_run();
      end
    end while (wb_ack_o !== 1'b1);
    rdata    = wb_dat_o;
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_we_i  = 1'b0;
    next_cycle();
    // ack is a single pulse
    check_value("wb_ack_o", 32'(wb_ack_o), 32'd0);
  endtask

  task automatic read_ctrl();
    wb_data_t rd;
    int       cycles;
    bus_access(REG_CTRL, 1'b0, 2'b11, 16'h0000, rd, cycles);
    check_value("ctrl read ack latency", cycles, 1);
    check_value("wb_dat_o ctrl", 32'(rd), 32'({model_div, 7'd0, model_ss}));
  endtask

  // junk lands in the unused control bits
  task automatic ctrl_write(input logic ss_v, input clk_div_t div_v,
                            input logic [1:0] sel, input logic [6:0] junk);
    wb_data_t rd;
    int       cycles;
    bus_access(REG_CTRL, 1'b1, sel, {div_v, junk, ss_v}, rd, cycles);
    check_value("ctrl write ack latency", cycles, 1);
    if (sel[0]) begin
      model_ss = ss_v;
    end
    if (sel[1]) begin
      model_div = div_v;
    end
    check_value("ss_o", 32'(ss), 32'(model_ss));
    read_ctrl();
  endtask

  task automatic data_access(input logic we, input spi_byte_t wr_byte, input spi_byte_t junk);
    wb_data_t  rd;
    int        cycles;
    spi_byte_t sent;
    // reads clock out all ones
    sent = we ? wr_byte : 8'hff;
    bus_access(REG_DATA, we, 2'b11, {junk, wr_byte}, rd, cycles);
    check_value("data ack latency", cycles, 16 * (int'(model_div) + 1) + 2);
    if (!we) begin
      check_value("wb_dat_o data", 32'(rd), 32'({8'h00, model_answer}));
    end
    model_bytes++;
    check_value("card byte count", card_bytes, model_bytes);
    check_value("card mosi byte", 32'(card_rx), 32'(sent));
    model_answer = sent ^ 8'ha5;
  endtask

  // between accesses the pads sit idle
  task automatic check_idle();
    check_value("sclk_o", 32'(sclk), 32'd1);
    check_value("mosi_o", 32'(mosi), 32'd1);
    check_value("card idle edges", card_idle_edges, idle_base);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
    abort_run();
  end

  initial begin
    logic [31:0] r;
    int          kind;
    void'($urandom(SEED));
    reset_i      = 1'b1;
    wb_adr_i     = 1'b0;
    wb_dat_i     = '0;
    wb_we_i      = 1'b0;
    wb_sel_i     = 2'b00;
    wb_stb_i     = 1'b0;
    wb_cyc_i     = 1'b0;
    model_ss     = SS_RESET;
    model_div    = DIV_TB;
    model_answer = 8'hff;
    model_bytes  = 0;
    repeat (8) @(posedge wb_clk_i);
    #1;
    reset_i = 1'b0;
    next_cycle();
    idle_base = card_idle_edges;
    // reset state of the pads and control register
    check_value("ss_o", 32'(ss), 32'd1);
    check_value("wb_ack_o", 32'(wb_ack_o), 32'd0);
    check_idle();
    read_ctrl();
    for (int i = 0; i < NUM_TXN; i++) begin
      kind = $urandom % 3;
      r    = $urandom;
      if (kind == 0) begin
        ctrl_write(r[3], {5'd0, r[2:0]}, r[5:4], r[12:6]);
      end else begin
        // select the card before a data access
        if (model_ss) begin
          ctrl_write(1'b0, model_div, 2'b01, r[12:6]);
        end
        data_access(kind == 1, r[23:16], r[31:24]);
      end
      check_idle();
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

// File: hw/sdspi_clkgen.sv
// sd spi clock generator
// divides the bus clock into sclk and edge strobes while running
`timescale 1ns/1ps

module sdspi_clkgen import sdspi_pkg::*; (
  input  logic     wb_clk_i,
  input  logic     reset_i,
  input  clk_div_t clk_div_i,
  input  logic     run_i,
  output logic     sclk_o,
  output logic     sclk_fall_o,
  output logic     sclk_rise_o
);

  clk_div_t cnt_q;
  logic     sclk_q;
  logic     tick;

  // end of a half period
  assign tick = run_i && (cnt_q == '0);

  // strobe names the edge sclk takes at the next clock
  assign sclk_fall_o = tick & sclk_q;
  assign sclk_rise_o = tick & ~sclk_q;
  assign sclk_o      = sclk_q;

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      cnt_q  <= '0;
      sclk_q <= 1'b1;
    end else if (!run_i) begin
      // idle, sclk parked high and counter ready
      cnt_q  <= clk_div_i;
      sclk_q <= 1'b1;
    end else if (tick) begin
      // reload and flip sclk
      cnt_q  <= clk_div_i;
      sclk_q <= ~sclk_q;
    end else begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

endmodule

// File: hw/sdspi_pkg.sv
// sd card spi controller shared definitions
// bus and byte types, register map and reset values
package sdspi_pkg;

  // wishbone data word
  typedef logic [15:0] wb_data_t;
  // one spi transfer byte
  typedef logic [7:0] spi_byte_t;
  // sclk half period is divisor + 1 clocks
  typedef logic [7:0] clk_div_t;
  // bit index within a byte
  typedef logic [2:0] bit_cnt_t;

  // register offsets on wb_adr_i
  localparam logic REG_DATA = 1'b0;
  localparam logic REG_CTRL = 1'b1;

  // control register layout
  localparam int CTRL_SS_BIT  = 0;
  localparam int CTRL_DIV_LSB = 8;

  // reset values, card deselected and slow init clock
  localparam logic     SS_RESET  = 1'b1;
  localparam clk_div_t DIV_RESET = 8'd124;

endpackage

// File: hw/sdspi_regs.sv
// sd spi register block
// wishbone decode, control register, transfer launch and ack
`timescale 1ns/1ps

module sdspi_regs import sdspi_pkg::*; #(
  parameter clk_div_t DIV_INIT = DIV_RESET
) (
  input  logic       wb_clk_i,
  input  logic       reset_i,
  input  logic       wb_adr_i,
  input  wb_data_t   wb_dat_i,
  output wb_data_t   wb_dat_o,
  input  logic       wb_we_i,
  input  logic [1:0] wb_sel_i,
  input  logic       wb_stb_i,
  input  logic       wb_cyc_i,
  output logic       wb_ack_o,
  output logic       xfer_start_o,
  output spi_byte_t  tx_byte_o,
  input  logic       xfer_done_i,
  input  spi_byte_t  rx_byte_i,
  output clk_div_t   clk_div_o,
  output logic       ss_o
);

  logic      ack_q;
  logic      busy_q;
  logic      start_q;
  logic      ss_q;
  clk_div_t  div_q;
  wb_data_t  dat_q;
  spi_byte_t tx_q;
  logic      bus_req;
  logic      new_req;
  wb_data_t  ctrl_rd;

  // valid cycle from the master
  assign bus_req = wb_stb_i & wb_cyc_i;
  // first cycle only, not while acking or a transfer is out
  assign new_req = bus_req & ~ack_q & ~busy_q;

  // control register as seen on a read
  always_comb begin
    ctrl_rd = '0;
    ctrl_rd[CTRL_SS_BIT] = ss_q;
    ctrl_rd[CTRL_DIV_LSB +: $bits(clk_div_t)] = div_q;
  end

  // control state
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      ack_q   <= 1'b0;
      busy_q  <= 1'b0;
      start_q <= 1'b0;
      ss_q    <= SS_RESET;
      div_q   <= DIV_INIT;
    end else begin
      // ack and start are one cycle pulses
      ack_q   <= 1'b0;
      start_q <= 1'b0;
      if (new_req && wb_adr_i == REG_CTRL) begin
        // control access acks right away
        ack_q <= 1'b1;
        if (wb_we_i) begin
          // lane 0 carries slave select
          if (wb_sel_i[0]) begin
            ss_q <= wb_dat_i[CTRL_SS_BIT];
          end
          // lane 1 carries the divisor
          if (wb_sel_i[1]) begin
            div_q <= wb_dat_i[CTRL_DIV_LSB +: $bits(clk_div_t)];
          end
        end
      end else if (new_req && wb_adr_i == REG_DATA) begin
        // data access, kick the shifter and hold the bus
        busy_q  <= 1'b1;
        start_q <= 1'b1;
      end else if (busy_q && xfer_done_i) begin
        // byte is done, release the master
        busy_q <= 1'b0;
        ack_q  <= 1'b1;
      end
    end
  end

  // payload registers
  always_ff @(posedge wb_clk_i) begin
    if (new_req && wb_adr_i == REG_DATA) begin
      // reads clock out all ones
      tx_q <= wb_we_i ? wb_dat_i[7:0] : 8'hff;
    end
    if (new_req && wb_adr_i == REG_CTRL) begin
      dat_q <= ctrl_rd;
    end else if (busy_q && xfer_done_i) begin
      // received byte in the low lane
      dat_q <= {8'h00, rx_byte_i};
    end
  end

  assign wb_ack_o     = ack_q;
  assign wb_dat_o     = dat_q;
  assign xfer_start_o = start_q;
  assign tx_byte_o    = tx_q;
  assign clk_div_o    = div_q;
  assign ss_o         = ss_q;

endmodule

// File: hw/sdspi_shifter.sv
// sd spi shift engine
// sends one byte msb first on mosi and collects one byte from miso
`timescale 1ns/1ps

module sdspi_shifter import sdspi_pkg::*; (
  input  logic      wb_clk_i,
  input  logic      reset_i,
  input  logic      xfer_start_i,
  input  spi_byte_t tx_byte_i,
  input  logic      sclk_fall_i,
  input  logic      sclk_rise_i,
  input  logic      miso_i,
  output logic      run_o,
  output logic      mosi_o,
  output spi_byte_t rx_byte_o,
  output logic      xfer_done_o
);

  typedef enum logic {
    SH_IDLE,
    SH_SHIFT
  } sh_state_e;

  sh_state_e state_q;
  bit_cnt_t  bit_cnt_q;
  spi_byte_t tx_sr_q;
  spi_byte_t rx_sr_q;
  spi_byte_t tx_cur;
  logic      mosi_q;
  logic      done_q;
  logic      last_rise;

  // with a zero divisor the first fall lands in the start cycle
  assign tx_cur = xfer_start_i ? tx_byte_i : tx_sr_q;

  // clock runs from the start cycle on
  assign run_o = (state_q == SH_SHIFT) | xfer_start_i;

  // rise of bit 7 ends the byte
  assign last_rise = sclk_rise_i && (bit_cnt_q == 3'd7);

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      state_q <= SH_IDLE;
    end else begin
      case (state_q)
        SH_IDLE: begin
          if (xfer_start_i) begin
            state_q <= SH_SHIFT;
          end
        end
        SH_SHIFT: begin
          if (last_rise) begin
            state_q <= SH_IDLE;
          end
        end
        default: state_q <= SH_IDLE;
      endcase
    end
  end

  // bit counter, mosi level and done pulse
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      bit_cnt_q <= '0;
      mosi_q    <= 1'b1;
      done_q    <= 1'b0;
    end else begin
      done_q <= last_rise;
      if (xfer_start_i) begin
        bit_cnt_q <= '0;
      end else if (sclk_rise_i) begin
        // wraps back to 0 after bit 7
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
      if (sclk_fall_i) begin
        mosi_q <= tx_cur[7];
      end else if (last_rise) begin
        // line idles high between bytes
        mosi_q <= 1'b1;
      end
    end
  end

  // shift registers
  always_ff @(posedge wb_clk_i) begin
    if (sclk_fall_i) begin
      tx_sr_q <= {tx_cur[6:0], 1'b1};
    end else if (xfer_start_i) begin
      tx_sr_q <= tx_byte_i;
    end
    // miso sampled as sclk goes high
    if (sclk_rise_i) begin
      rx_sr_q <= {rx_sr_q[6:0], miso_i};
    end
  end

  assign mosi_o      = mosi_q;
  assign rx_byte_o   = rx_sr_q;
  assign xfer_done_o = done_q;

endmodule

// File: hw/sdspi_top.sv
// sd card spi controller top
// wishbone slave with programmable sclk, one byte per data access
`timescale 1ns/1ps

module sdspi_top import sdspi_pkg::*; #(
  parameter clk_div_t DIV_INIT = DIV_RESET
) (
  // wishbone slave
  input  logic       wb_clk_i,
  input  logic       reset_i,
  input  logic       wb_adr_i,
  input  wb_data_t   wb_dat_i,
  output wb_data_t   wb_dat_o,
  input  logic       wb_we_i,
  input  logic [1:0] wb_sel_i,
  input  logic       wb_stb_i,
  input  logic       wb_cyc_i,
  output logic       wb_ack_o,
  // card pads
  output logic       sclk_o,
  output logic       mosi_o,
  input  logic       miso_i,
  output logic       ss_o
);

  logic      xfer_start;
  logic      xfer_done;
  spi_byte_t tx_byte;
  spi_byte_t rx_byte;
  clk_div_t  clk_div;
  logic      run;
  logic      sclk_fall;
  logic      sclk_rise;

  // bus side and control register
  sdspi_regs #(
    .DIV_INIT (DIV_INIT)
  ) u_regs (
    .wb_clk_i     (wb_clk_i),
    .reset_i      (reset_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_we_i      (wb_we_i),
    .wb_sel_i     (wb_sel_i),
    .wb_stb_i     (wb_stb_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_ack_o     (wb_ack_o),
    .xfer_start_o (xfer_start),
    .tx_byte_o    (tx_byte),
    .xfer_done_i  (xfer_done),
    .rx_byte_i    (rx_byte),
    .clk_div_o    (clk_div),
    .ss_o         (ss_o)
  );

  // sclk and edge strobes
  sdspi_clkgen u_clkgen (
    .wb_clk_i    (wb_clk_i),
    .reset_i     (reset_i),
    .clk_div_i   (clk_div),
    .run_i       (run),
    .sclk_o      (sclk_o),
    .sclk_fall_o (sclk_fall),
    .sclk_rise_o (sclk_rise)
  );

  // byte engine
  sdspi_shifter u_shifter (
    .wb_clk_i     (wb_clk_i),
    .reset_i      (reset_i),
    .xfer_start_i (xfer_start),
    .tx_byte_i    (tx_byte),
    .sclk_fall_i  (sclk_fall),
    .sclk_rise_i  (sclk_rise),
    .miso_i       (miso_i),
    .run_o        (run),
    .mosi_o       (mosi_o),
    .rx_byte_o    (rx_byte),
    .xfer_done_o  (xfer_done)
  );

endmodule

// File: run.sh
#!/bin/sh
# compile and run the sd spi testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 -f sources.f --top-module sdspi_tb -o sdspi_sim
./obj_dir/sdspi_sim

// File: sources.f
hw/sdspi_pkg.sv
hw/sdspi_regs.sv
hw/sdspi_clkgen.sv
hw/sdspi_shifter.sv
hw/sdspi_top.sv
dv/sd_card_model.sv
dv/sdspi_tb.sv
